/* bench/fsync_stim.txt */
# Columns: BAR level first_tile W|R, PAIRS, LONE tile level, MIX tile level_a level_b, WAIT cycles
# Numbers are decimal; W expects a wake, R a reject of the whole group
BAR 1 0 W
BAR 1 6 W
BAR 1 14 W
BAR 2 4 W
BAR 2 12 W
BAR 3 0 W
BAR 3 8 W
BAR 4 0 W
WAIT 10
BAR 2 0 W
BAR 4 0 W
BAR 3 8 W
PAIRS
WAIT 5
BAR 1 10 W
MIX 6 1 2
WAIT 20
BAR 2 8 W
MIX 0 3 1
LONE 10 2
WAIT 4
LONE 3 2
BAR 5 0 R
WAIT 6
BAR 4 0 W
PAIRS
BAR 3 0 W
BAR 1 2 W
WAIT 8

/* bench/tb_fsync_network.sv */
// Self-checking testbench for the 16-tile barrier sync network.
// Commands come from bench/fsync_stim.txt and are read relative to the project root.
// Random gaps between the strobes of one barrier add up to at most 48 cycles.
// Stops at the first error.
`timescale 1ns/10ps
`default_nettype none

module tb_fsync_network;

  localparam int N_TILES       = 16;
  localparam int WAIT_LIMIT    = 64;
  localparam int LEVELS        = 4;
  localparam int PULSE_TIMEOUT = 200;
  localparam int SPREAD_BUDGET = 48;
  localparam logic [31:0] SEED = 32'h28d6;

  typedef logic [N_TILES-1:0] tile_vec_t;

  logic                          clk_i;
  logic                          rst_i;
  tile_vec_t                     sync_req_i;
  fsync_pkg::lvl_t [N_TILES-1:0] sync_lvl_i;
  tile_vec_t                     busy_o;
  tile_vec_t                     wake_o;
  tile_vec_t                     reject_o;
  logic                          error_o;
  fsync_pkg::cnt_t               error_cnt_o;
  fsync_pkg::cnt_t               barrier_cnt_o;

  logic [31:0]     rnd_state;
  fsync_pkg::cnt_t exp_errors;
  fsync_pkg::cnt_t exp_barriers;
  logic            error_seen;

  fsync_network #(
    .N_TILES    ( N_TILES    ),
    .WAIT_LIMIT ( WAIT_LIMIT )
  ) i_fsync_network (
    .clk_i,
    .rst_i,
    .sync_req_i,
    .sync_lvl_i,
    .busy_o,
    .wake_o,
    .reject_o,
    .error_o,
    .error_cnt_o,
    .barrier_cnt_o
  );

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next(logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Tiles in a group at level lvl, the whole mesh above the root
  function automatic int group_size(int lvl);
    return (lvl > LEVELS) ? N_TILES : (1 << lvl);
  endfunction

  function automatic tile_vec_t group_mask(int lvl, int first);
    tile_vec_t mask;
    mask = '0;
    for (int i = 0; i < N_TILES; i++) begin
      mask[i] = (i >= first) && (i < first + group_size(lvl));
    end
    return mask;
  endfunction

  task automatic draw_random(input int n, output int val);
    rnd_state = lcg_next(rnd_state);
    val = int'(rnd_state[30:16]) % n;
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_vec(input string name, input tile_vec_t got, input tile_vec_t exp);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_cnt(input string name, input fsync_pkg::cnt_t got,
                           input fsync_pkg::cnt_t exp);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    end
  endtask

  // Strobe every tile of mask once, in shuffled order with random gaps
  task automatic strobe_group(input tile_vec_t mask, input fsync_pkg::lvl_t lvl);
    int order[$];
    int pick;
    int gap;
    int spent;
    int tmp;
    tile_vec_t pending;
    for (int i = 0; i < N_TILES; i++) begin
      if (mask[i]) order.push_back(i);
    end
    for (int i = order.size() - 1; i > 0; i--) begin
      draw_random(i + 1, pick);
      tmp = order[i];
      order[i] = order[pick];
      order[pick] = tmp;
    end
    spent = 0;
    pending = '0;
    foreach (order[k]) begin
      sync_req_i[order[k]] = 1'b1;
      sync_lvl_i[order[k]] = lvl;
      pending[order[k]] = 1'b1;
      @(negedge clk_i);
      sync_req_i = '0;
      // Every strobed tile is busy until the group is complete
      check_vec("busy_o", busy_o, pending);
      // No gap after the last strobe since the reply may follow quickly
      if (k < order.size() - 1) begin
        draw_random(8, gap);
        if (spent + gap > SPREAD_BUDGET) gap = 0;
        spent += gap;
        repeat (gap) @(negedge clk_i);
      end
    end
  endtask

  task automatic wait_pulse(input string what, output tile_vec_t wakes,
                            output tile_vec_t rejects);
    logic found;
    found = 1'b0;
    wakes = '0;
    rejects = '0;
    for (int c = 0; (c < PULSE_TIMEOUT) && !found; c++) begin
      if ((wake_o | reject_o) != '0) begin
        found = 1'b1;
        wakes = wake_o;
        rejects = reject_o;
      end else begin
        @(negedge clk_i);
      end
    end
    if (!found) begin
      abort_run($sformatf("Timeout: no wake_o or reject_o pulse for %s within %0d cycles",
                          what, PULSE_TIMEOUT));
    end
  endtask

  // Pulse cycle must match, then everything goes idle and the counts move
  task automatic close_barrier(input tile_vec_t exp_wake, input tile_vec_t exp_rej,
                               input tile_vec_t wakes, input tile_vec_t rejects);
    check_vec("wake_o", wakes, exp_wake);
    check_vec("reject_o", rejects, exp_rej);
    @(negedge clk_i);
    if (exp_wake != '0) exp_barriers = exp_barriers + 16'd1;
    if (exp_rej != '0) begin
      exp_errors = exp_errors + 16'd1;
      error_seen = 1'b1;
    end
    check_vec("wake_o", wake_o, '0);
    check_vec("reject_o", reject_o, '0);
    check_vec("busy_o", busy_o, '0);
    check_cnt("barrier_cnt_o", barrier_cnt_o, exp_barriers);
    check_cnt("error_cnt_o", error_cnt_o, exp_errors);
    check_bit("error_o", error_o, error_seen);
  endtask

  initial begin
    int fd;
    int code;
    int a;
    int b;
    int c;
    string cmd;
    string line;
    string outcome;
    tile_vec_t mask;
    tile_vec_t wakes;
    tile_vec_t rejects;
    tile_vec_t seen;
    rnd_state = SEED;
    rst_i = 1'b1;
    sync_req_i = '0;
    sync_lvl_i = '0;
    exp_errors = '0;
    exp_barriers = '0;
    error_seen = 1'b0;
    repeat (5) @(negedge clk_i);
    rst_i = 1'b0;
    @(negedge clk_i);
    check_vec("busy_o", busy_o, '0);
    check_vec("wake_o", wake_o, '0);
    check_vec("reject_o", reject_o, '0);
    check_bit("error_o", error_o, 1'b0);
    check_cnt("error_cnt_o", error_cnt_o, '0);
    check_cnt("barrier_cnt_o", barrier_cnt_o, '0);

    fd = $fopen("bench/fsync_stim.txt", "r");
    if (fd == 0) abort_run("Could not open bench/fsync_stim.txt");
    while (!$feof(fd)) begin
      code = $fscanf(fd, "%s", cmd);
      if (code != 1) break;
      if (cmd.substr(0, 0) == "#") begin
        code = $fgets(line, fd);
      end else if (cmd == "BAR") begin
        code = $fscanf(fd, "%d %d %s", a, b, outcome);
        if ((code != 3) || (a < 1) || (a > 7) || (b < 0) || (b >= N_TILES) ||
            ((b % group_size(a)) != 0)) begin
          abort_run("Bad BAR line in stim file");
        end
        mask = group_mask(a, b);
        strobe_group(mask, fsync_pkg::lvl_t'(a));
        wait_pulse($sformatf("BAR level %0d at tile %0d", a, b), wakes, rejects);
        if (outcome == "W") close_barrier(mask, '0, wakes, rejects);
        else close_barrier('0, mask, wakes, rejects);
      end else if (cmd == "PAIRS") begin
        sync_req_i = '1;
        for (int i = 0; i < N_TILES; i++) sync_lvl_i[i] = 3'd1;
        @(negedge clk_i);
        sync_req_i = '0;
        seen = '0;
        for (int n = 0; (n < N_TILES / 2) && (seen != '1); n++) begin
          wait_pulse("PAIRS", wakes, rejects);
          check_vec("reject_o", rejects, '0);
          seen = seen | wakes;
          @(negedge clk_i);
        end
        check_vec("wake_o union", seen, '1);
        exp_barriers = exp_barriers + 16'd8;
        check_cnt("barrier_cnt_o", barrier_cnt_o, exp_barriers);
        check_vec("busy_o", busy_o, '0);
      end else if (cmd == "LONE") begin
        code = $fscanf(fd, "%d %d", a, b);
        if ((code != 2) || (a < 0) || (a >= N_TILES) || (b < 1)) begin
          abort_run("Bad LONE line in stim file");
        end
        mask = tile_vec_t'(1) << a;
        strobe_group(mask, fsync_pkg::lvl_t'(b));
        wait_pulse($sformatf("LONE at tile %0d", a), wakes, rejects);
        close_barrier('0, mask, wakes, rejects);
      end else if (cmd == "MIX") begin
        code = $fscanf(fd, "%d %d %d", a, b, c);
        if ((code != 3) || (a % 2 != 0) || (a >= N_TILES) || (b == c)) begin
          abort_run("Bad MIX line in stim file");
        end
        // Siblings strobe together with different levels
        sync_req_i[a] = 1'b1;
        sync_req_i[a+1] = 1'b1;
        sync_lvl_i[a] = fsync_pkg::lvl_t'(b);
        sync_lvl_i[a+1] = fsync_pkg::lvl_t'(c);
        @(negedge clk_i);
        sync_req_i = '0;
        wait_pulse($sformatf("MIX at tile %0d", a), wakes, rejects);
        close_barrier('0, tile_vec_t'(3) << a, wakes, rejects);
      end else if (cmd == "WAIT") begin
        code = $fscanf(fd, "%d", a);
        if (code != 1) abort_run("Bad WAIT line in stim file");
        repeat (a) @(negedge clk_i);
        check_bit("error_o", error_o, error_seen);
        check_vec("busy_o", busy_o, '0);
      end else begin
        abort_run($sformatf("Unknown command %s in stim file", cmd));
      end
    end
    $fclose(fd);
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* logic/fsync_if.sv */
// Parent/child link of the sync tree.
// The child holds req and lvl until it sees wake or rej. The parent pulses
// wake or rej for one cycle and only towards a child whose req is high.
`timescale 1ns/10ps
`default_nettype none

interface fsync_if;

  // Child to parent
  logic            req;
  fsync_pkg::lvl_t lvl;

  // Parent to child, one-cycle pulses
  logic            wake;
  logic            rej;

  modport parent (
    input  req,
    input  lvl,
    output wake,
    output rej
  );

  modport child (
    output req,
    output lvl,
    input  wake,
    input  rej
  );

endinterface

`default_nettype wire

/* logic/fsync_monitor.sv */
// Collects node pulses into a sticky error flag and two counters.
// Both counters saturate at all ones. Outputs follow a pulse by one cycle.
// error_o clears only on reset.
`timescale 1ns/10ps
`default_nettype none

module fsync_monitor #(
  parameter int unsigned N_NODES = fsync_pkg::DEFAULT_N_TILES - 1
) (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic [N_NODES-1:0] done_i,
  input  logic [N_NODES-1:0] err_i,
  output logic               error_o,
  output fsync_pkg::cnt_t    error_cnt_o,
  output fsync_pkg::cnt_t    barrier_cnt_o
);

  logic            error_q;
  fsync_pkg::cnt_t error_cnt_q;
  fsync_pkg::cnt_t barrier_cnt_q;

  // Add the number of set bits, clamping at the counter maximum
  function automatic fsync_pkg::cnt_t sat_add(fsync_pkg::cnt_t base, logic [N_NODES-1:0] bits);
    logic [fsync_pkg::CNT_W:0] sum;
    sum = {1'b0, base};
    for (int i = 0; i < N_NODES; i++) begin
      sum = sum + (fsync_pkg::CNT_W + 1)'(bits[i]);
    end
    return sum[fsync_pkg::CNT_W] ? '1 : sum[fsync_pkg::CNT_W-1:0];
  endfunction

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      error_q       <= 1'b0;
      error_cnt_q   <= '0;
      barrier_cnt_q <= '0;
    end else begin
      error_q       <= error_q || (|err_i);
      error_cnt_q   <= sat_add(error_cnt_q, err_i);
      barrier_cnt_q <= sat_add(barrier_cnt_q, done_i);
    end
  end

  assign error_o       = error_q;
  assign error_cnt_o   = error_cnt_q;
  assign barrier_cnt_o = barrier_cnt_q;

endmodule

`default_nettype wire

/* logic/fsync_network.sv */
// Barrier sync network for N_TILES tiles, built as a binary tree.
// N_TILES must be a power of two, at least 2, and LEVELS = log2(N_TILES)
// must fit below the top lvl_t value. Tiles 2j and 2j+1 share a depth-1 node.
// Strobes are single-cycle; a strobe while busy is ignored.
`timescale 1ns/10ps
`default_nettype none

module fsync_network #(
  parameter int unsigned N_TILES    = fsync_pkg::DEFAULT_N_TILES,
  parameter int unsigned WAIT_LIMIT = fsync_pkg::DEFAULT_WAIT_LIMIT
) (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic            [N_TILES-1:0]  sync_req_i,
  input  fsync_pkg::lvl_t [N_TILES-1:0]  sync_lvl_i,
  output logic            [N_TILES-1:0]  busy_o,
  output logic            [N_TILES-1:0]  wake_o,
  output logic            [N_TILES-1:0]  reject_o,
  output logic                           error_o,
  output fsync_pkg::cnt_t                error_cnt_o,
  output fsync_pkg::cnt_t                barrier_cnt_o
);

  localparam int unsigned LEVELS  = $clog2(N_TILES);
  localparam int unsigned N_NODES = N_TILES - 1;

  if ((N_TILES < 2) || ((N_TILES & (N_TILES - 1)) != 0)) begin : gen_bad_size
    $fatal(1, "fsync_network needs a power-of-two tile count of at least 2");
  end

  // Heap numbering: element k (root is 1, tiles are N_TILES..2*N_TILES-1)
  // talks to its parent over links[k-1]
  fsync_if links [2*N_TILES-1] ();

  logic [N_NODES-1:0] node_done;
  logic [N_NODES-1:0] node_err;

  // Nothing above the root
  assign links[0].wake = 1'b0;
  assign links[0].rej  = 1'b0;

  for (genvar t = 0; t < N_TILES; t++) begin : gen_tile
    fsync_tile_port i_fsync_tile_port (
      .clk_i,
      .rst_i,
      .req_i    ( sync_req_i[t]         ),
      .lvl_i    ( sync_lvl_i[t]         ),
      .up       ( links[N_TILES+t-1]    ),
      .busy_o   ( busy_o[t]             ),
      .wake_o   ( wake_o[t]             ),
      .reject_o ( reject_o[t]           )
    );
  end

  // Depth d holds nodes N_TILES>>d .. (N_TILES>>(d-1))-1
  for (genvar d = 1; d <= LEVELS; d++) begin : gen_depth
    for (genvar j = 0; j < (N_TILES >> d); j++) begin : gen_node
      localparam int unsigned K = (N_TILES >> d) + j;

      fsync_node #(
        .DEPTH      ( d          ),
        .LEVELS     ( LEVELS     ),
        .WAIT_LIMIT ( WAIT_LIMIT )
      ) i_fsync_node (
        .clk_i,
        .rst_i,
        .left   ( links[2*K-1]   ),
        .right  ( links[2*K]     ),
        .up     ( links[K-1]     ),
        .done_o ( node_done[K-1] ),
        .err_o  ( node_err[K-1]  )
      );
    end
  end

  fsync_monitor #(
    .N_NODES ( N_NODES )
  ) i_fsync_monitor (
    .clk_i,
    .rst_i,
    .done_i        ( node_done     ),
    .err_i         ( node_err      ),
    .error_o       ( error_o       ),
    .error_cnt_o   ( error_cnt_o   ),
    .barrier_cnt_o ( barrier_cnt_o )
  );

endmodule

`default_nettype wire

/* logic/fsync_node.sv */
// Tree node at depth DEPTH (1 pairs two tiles, LEVELS is the root).
// One barrier is pending at a time. The root never forwards, so a level
// above LEVELS ends there as a reject. A lone child waiting WAIT_LIMIT
// cycles is rejected by the watchdog.
`timescale 1ns/10ps
`default_nettype none

module fsync_node #(
  parameter int unsigned DEPTH      = 1,
  parameter int unsigned LEVELS     = 4,
  parameter int unsigned WAIT_LIMIT = fsync_pkg::DEFAULT_WAIT_LIMIT
) (
  input  logic    clk_i,
  input  logic    rst_i,
  fsync_if.parent left,
  fsync_if.parent right,
  fsync_if.child  up,
  output logic    done_o,
  output logic    err_o
);

  localparam bit IS_ROOT = (DEPTH == LEVELS);
  localparam fsync_pkg::lvl_t MY_LVL = fsync_pkg::lvl_t'(DEPTH);

  fsync_pkg::node_state_e state_q;
  fsync_pkg::lvl_t        lvl_q;
  logic                   up_req_q;
  logic                   rep_left_q;
  logic                   rep_right_q;
  logic                   rep_wake_q;
  logic                   done_q;
  logic                   err_q;
  logic                   both_req;
  logic                   timer_run;
  logic                   expire;
  logic                   lvl_match;

  assign both_req  = left.req && right.req;
  assign lvl_match = (left.lvl == right.lvl);
  assign timer_run = (state_q == fsync_pkg::COLLECT) && (left.req ^ right.req);

  fsync_wait_timer #(
    .WAIT_LIMIT ( WAIT_LIMIT )
  ) i_fsync_wait_timer (
    .clk_i,
    .rst_i,
    .run_i    ( timer_run ),
    .expire_o ( expire    )
  );

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= fsync_pkg::COLLECT;
      up_req_q    <= 1'b0;
      rep_left_q  <= 1'b0;
      rep_right_q <= 1'b0;
      rep_wake_q  <= 1'b0;
      done_q      <= 1'b0;
      err_q       <= 1'b0;
    end else begin
      done_q <= 1'b0;
      err_q  <= 1'b0;
      case (state_q)
        fsync_pkg::COLLECT: begin
          if (both_req) begin
            rep_left_q  <= 1'b1;
            rep_right_q <= 1'b1;
            if (lvl_match && (left.lvl == MY_LVL)) begin
              // Whole group is here
              rep_wake_q <= 1'b1;
              done_q     <= 1'b1;
              state_q    <= fsync_pkg::REPLY;
            end else if (lvl_match && (left.lvl > MY_LVL) && !IS_ROOT) begin
              up_req_q <= 1'b1;
              state_q  <= fsync_pkg::FORWARDED;
            end else begin
              // Mismatch, a level too low, or above the root
              rep_wake_q <= 1'b0;
              err_q      <= 1'b1;
              state_q    <= fsync_pkg::REPLY;
            end
          end else if (expire) begin
            rep_left_q  <= left.req;
            rep_right_q <= right.req;
            rep_wake_q  <= 1'b0;
            err_q       <= 1'b1;
            state_q     <= fsync_pkg::REPLY;
          end
        end
        fsync_pkg::FORWARDED: begin
          // Relay the parent's verdict; the error was counted up there
          if (up.wake || up.rej) begin
            up_req_q   <= 1'b0;
            rep_wake_q <= up.wake;
            state_q    <= fsync_pkg::REPLY;
          end
        end
        default: begin
          state_q <= fsync_pkg::COLLECT;
        end
      endcase
    end
  end

  // Both children carry the same level when forwarded
  always_ff @(posedge clk_i) begin
    if ((state_q == fsync_pkg::COLLECT) && both_req) begin
      lvl_q <= left.lvl;
    end
  end

  assign left.wake  = (state_q == fsync_pkg::REPLY) && rep_left_q && rep_wake_q;
  assign left.rej   = (state_q == fsync_pkg::REPLY) && rep_left_q && !rep_wake_q;
  assign right.wake = (state_q == fsync_pkg::REPLY) && rep_right_q && rep_wake_q;
  assign right.rej  = (state_q == fsync_pkg::REPLY) && rep_right_q && !rep_wake_q;
  assign up.req     = up_req_q;
  assign up.lvl     = lvl_q;
  assign done_o     = done_q;
  assign err_o      = err_q;

  // Replies only reach a child still holding req, and never both kinds
  assert property (@(posedge clk_i) disable iff (rst_i)
    (left.wake || left.rej) |-> (left.req && !(left.wake && left.rej)));
  assert property (@(posedge clk_i) disable iff (rst_i)
    (right.wake || right.rej) |-> (right.req && !(right.wake && right.rej)));

  if (IS_ROOT) begin : gen_root_chk
    assert property (@(posedge clk_i) disable iff (rst_i) !up.req);
  end

endmodule

`default_nettype wire

/* logic/fsync_pkg.sv */
// Shared types and default sizes of the barrier sync network.
// Level 0 is unused. Levels 1 to LEVELS are legal and larger values get rejected.
// LVL_W must hold LEVELS+1 so that an over-range request can still be encoded.
`default_nettype none

package fsync_pkg;

  // Barrier level carried up the tree
  localparam int unsigned LVL_W = 3;
  typedef logic [LVL_W-1:0] lvl_t;

  // Mesh size and watchdog defaults
  localparam int unsigned DEFAULT_N_TILES    = 16;
  localparam int unsigned DEFAULT_WAIT_LIMIT = 64;

  // Monitor counters saturate at all ones
  localparam int unsigned CNT_W = 16;
  typedef logic [CNT_W-1:0] cnt_t;

  // Node FSM
  // COLLECT   waits for both children
  // FORWARDED waits for the parent's reply
  // REPLY     drives wake or rej for one cycle
  typedef enum logic [1:0] {
    COLLECT   = 2'd0,
    FORWARDED = 2'd1,
    REPLY     = 2'd2
  } node_state_e;

endpackage

`default_nettype wire

/* logic/fsync_tile_port.sv */
// Tile-side leaf of the sync tree. It holds one pending barrier per tile.
// A strobe while busy is illegal and is dropped. The reply pulses reach
// wake_o and reject_o combinationally, in the same cycle as on the link.
`timescale 1ns/10ps
`default_nettype none

module fsync_tile_port (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            req_i,
  input  fsync_pkg::lvl_t lvl_i,
  fsync_if.child          up,
  output logic            busy_o,
  output logic            wake_o,
  output logic            reject_o
);

  logic            busy_q;
  fsync_pkg::lvl_t lvl_q;
  logic            accept;
  logic            reply;

  assign accept = req_i && !busy_q;
  assign reply  = up.wake || up.rej;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q <= 1'b0;
    end else if (busy_q && reply) begin
      busy_q <= 1'b0;
    end else if (accept) begin
      busy_q <= 1'b1;
    end
  end

  // Level of the pending barrier
  always_ff @(posedge clk_i) begin
    if (accept) begin
      lvl_q <= lvl_i;
    end
  end

  assign up.req   = busy_q;
  assign up.lvl   = lvl_q;
  assign busy_o   = busy_q;
  assign wake_o   = up.wake;
  assign reject_o = up.rej;

  // Tile side must wait for the reply before the next barrier
  assert property (@(posedge clk_i) disable iff (rst_i)
    req_i |-> !busy_q);

  // Level 0 does not name any group
  assert property (@(posedge clk_i) disable iff (rst_i)
    req_i |-> (lvl_i != '0));

endmodule

`default_nettype wire

/* logic/fsync_wait_timer.sv */
// Watchdog for a node holding a lone child request.
// expire_o pulses once, WAIT_LIMIT cycles after run_i rises, and the count
// restarts whenever run_i drops. WAIT_LIMIT must be at least 1.
`timescale 1ns/10ps
`default_nettype none

module fsync_wait_timer #(
  parameter int unsigned WAIT_LIMIT = fsync_pkg::DEFAULT_WAIT_LIMIT
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic run_i,
  output logic expire_o
);

  // One spare value past the limit keeps the pulse single
  localparam int unsigned CNT_BITS = $clog2(WAIT_LIMIT + 2);
  localparam logic [CNT_BITS-1:0] LIMIT = CNT_BITS'(WAIT_LIMIT);

  logic [CNT_BITS-1:0] cnt_q;

  always_ff @(posedge clk_i) begin
    if (rst_i || !run_i) begin
      cnt_q <= '0;
    end else if (cnt_q <= LIMIT) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign expire_o = run_i && (cnt_q == LIMIT);

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
# The exit status is the simulator's, nonzero on any failure.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_fsync_network \
  -Mdir obj_dir \
  -f src.f

./obj_dir/Vtb_fsync_network

/* src.f */
logic/fsync_pkg.sv
logic/fsync_if.sv
logic/fsync_wait_timer.sv
logic/fsync_tile_port.sv
logic/fsync_node.sv
logic/fsync_monitor.sv
logic/fsync_network.sv
bench/tb_fsync_network.sv
